/* verilog.f */
osd_pkg.sv
osd_scratch_regs.sv
osd_regaccess.sv
osd_packet_demux.sv
osd_packet_arbiter.sv
osd_debug_subsys.sv
osd_debug_subsys_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps -f verilog.f \
   --top-module osd_debug_subsys_tb -Mdir obj_dir -o osd_debug_subsys_tb || exit 1
result=$(./obj_dir/osd_debug_subsys_tb)
echo "$result"
echo "$result" | grep -qx "TEST PASS" && exit 0 || exit 1

/* osd_debug_subsys_tb.sv */
`timescale 1ns/1ps

module osd_debug_subsys_tb;

   localparam logic [15:0] M0 = 16'h0010;
   localparam logic [15:0] M1 = 16'h0011;
   localparam logic [15:0] HOST = 16'h0001;   // Requester id
   localparam int MAX_ROWS = 40;
   localparam int CYCLES_PER_ROW = 200;

   logic        clk;
   logic        rst;
   logic        in_valid;
   logic [15:0] in_data;
   logic        in_last;
   logic        in_ready;
   logic        out_valid;
   logic [15:0] out_data;
   logic        out_last;
   logic        out_ready;
   logic [15:0] event_dest_0;
   logic [15:0] event_dest_1;
   logic        stall_0;
   logic        stall_1;

   // Stimulus table
   string       t_name [MAX_ROWS];
   logic [15:0] t_req [MAX_ROWS][8];
   int          t_req_n [MAX_ROWS];
   logic [15:0] t_rsp [MAX_ROWS][8];
   int          t_rsp_n [MAX_ROWS];     // 0 when the packet is dropped
   bit          t_chk [MAX_ROWS];
   logic [1:0]  t_stall [MAX_ROWS];     // {stall_1, stall_0}
   logic [15:0] t_ev0 [MAX_ROWS];
   logic [15:0] t_ev1 [MAX_ROWS];
   int          n_rows;
   bit          table_done;

   // Expected flits per module as {last, data}
   logic [16:0] exp_q [2][$];
   string       exp_name [2][$];
   logic [16:0] pkt [$];
   int          sent_pkts;
   int          got_pkts;

   osd_debug_subsys #(
      .MOD_ID_0(M0), .MOD_ID_1(M1),
      .MOD_VENDOR(16'h0001), .MOD_TYPE(16'h0002), .MOD_VERSION(16'h0003),
      .EVENT_DEST_DEFAULT(16'h0005), .CAN_STALL(1'b1), .MAX_REG_SIZE(32)
   ) UUT (
      .clk(clk), .rst(rst),
      .in_valid(in_valid), .in_data(in_data), .in_last(in_last), .in_ready(in_ready),
      .out_valid(out_valid), .out_data(out_data), .out_last(out_last),
      .out_ready(out_ready),
      .event_dest_0(event_dest_0), .event_dest_1(event_dest_1),
      .stall_0(stall_0), .stall_1(stall_1)
   );

   function automatic logic [15:0] req_flags(input logic [1:0] ftype, input logic write,
                                             input logic [1:0] size);
      osd_pkg::osd_flags_u f;
      f = '0;
      f.req.ftype = ftype;
      f.req.write = write;
      f.req.size = size;
      return f;
   endfunction

   function automatic logic [15:0] resp_flags(input logic [3:0] subtype);
      osd_pkg::osd_flags_u f;
      f = '0;
      f.resp.ftype = osd_pkg::TYPE_REG;
      f.resp.subtype = subtype;
      return f;
   endfunction

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("TEST FAIL");
      $fatal(1);
   endtask

   // Request is dest, src, flags, addr, data; response is src, dest, flags, data
   task automatic add_row(input string name, input logic [15:0] dest,
                          input logic [15:0] flags, input logic [15:0] addr,
                          input int n_wr, input logic [31:0] wdata,
                          input logic [15:0] rflags, input int n_rd,
                          input logic [31:0] rdata);
      int r;
      r = n_rows;
      t_name[r] = name;
      t_req[r][0] = dest;
      t_req[r][1] = HOST;
      t_req[r][2] = flags;
      t_req[r][3] = addr;
      t_req[r][4] = (n_wr == 2) ? wdata[31:16] : wdata[15:0];   // MS word first
      t_req[r][5] = wdata[15:0];
      t_req_n[r] = 4 + n_wr;
      t_rsp[r][0] = HOST;
      t_rsp[r][1] = dest;
      t_rsp[r][2] = rflags;
      t_rsp[r][3] = (n_rd == 2) ? rdata[31:16] : rdata[15:0];
      t_rsp[r][4] = rdata[15:0];
      t_rsp_n[r] = 3 + n_rd;
      t_chk[r] = 1'b0;
      n_rows++;
   endtask

   task automatic add_drop(input string name, input logic [15:0] dest,
                           input logic [15:0] flags, input logic [15:0] addr);
      add_row(name, dest, flags, addr, 0, 32'h0, 16'h0, 0, 32'h0);
      t_rsp_n[n_rows - 1] = 0;
   endtask

   // Port values expected once the previous row has been answered
   task automatic expect_ports(input logic [1:0] stl, input logic [15:0] ev0,
                               input logic [15:0] ev1);
      t_chk[n_rows - 1] = 1'b1;
      t_stall[n_rows - 1] = stl;
      t_ev0[n_rows - 1] = ev0;
      t_ev1[n_rows - 1] = ev1;
   endtask

   task automatic build_table();
      logic [15:0] rd16, rd32, rd64, wr16, wr32, bad_type;
      logic [15:0] ok16, ok32, w_ok, w_err, r_err;
      rd16 = req_flags(osd_pkg::TYPE_REG, 1'b0, osd_pkg::SIZE_16);
      rd32 = req_flags(osd_pkg::TYPE_REG, 1'b0, osd_pkg::SIZE_32);
      rd64 = req_flags(osd_pkg::TYPE_REG, 1'b0, osd_pkg::SIZE_64);
      wr16 = req_flags(osd_pkg::TYPE_REG, 1'b1, osd_pkg::SIZE_16);
      wr32 = req_flags(osd_pkg::TYPE_REG, 1'b1, osd_pkg::SIZE_32);
      bad_type = req_flags(2'b01, 1'b0, osd_pkg::SIZE_16);
      ok16 = resp_flags({osd_pkg::RESP_READ_OK, osd_pkg::SIZE_16});
      ok32 = resp_flags({osd_pkg::RESP_READ_OK, osd_pkg::SIZE_32});
      w_ok = resp_flags(osd_pkg::RESP_WRITE_OK);
      w_err = resp_flags(osd_pkg::RESP_WRITE_ERR);
      r_err = resp_flags(osd_pkg::RESP_READ_ERR);

      // Base registers straight after reset
      add_row("rd_vendor_m0", M0, rd16, osd_pkg::REG_VENDOR, 0, 32'h0, ok16, 1, 32'h0001);
      add_row("rd_type_m1", M1, rd16, osd_pkg::REG_TYPE, 0, 32'h0, ok16, 1, 32'h0002);
      add_row("rd_version_m0", M0, rd16, osd_pkg::REG_VERSION, 0, 32'h0, ok16, 1, 32'h0003);
      add_row("rd_evdest_m1", M1, rd16, osd_pkg::REG_EVENT_DEST, 0, 32'h0, ok16, 1, 32'h0005);
      add_row("rd_cs_m0", M0, rd16, osd_pkg::REG_CS, 0, 32'h0, ok16, 1, 32'h0000);
      expect_ports(2'b11, 16'h0005, 16'h0005);
      add_row("wr_cs_m0", M0, wr16, osd_pkg::REG_CS, 1, 32'h0001, w_ok, 0, 32'h0);
      add_row("wr_evdest_m1", M1, wr16, osd_pkg::REG_EVENT_DEST, 1, 32'h0123, w_ok, 0, 32'h0);
      expect_ports(2'b10, 16'h0005, 16'h0123);
      add_row("rd_cs_m0_set", M0, rd16, osd_pkg::REG_CS, 0, 32'h0, ok16, 1, 32'h0001);
      add_row("rd_evdest_m1_new", M1, rd16, osd_pkg::REG_EVENT_DEST, 0, 32'h0, ok16, 1,
              32'h0123);
      // Scratch banks, separate per module
      add_row("wr_scr32_m0", M0, wr32, 16'h0200, 2, 32'hdeadbeef, w_ok, 0, 32'h0);
      add_row("wr_scr16_m1", M1, wr16, 16'h0201, 1, 32'h5a5a, w_ok, 0, 32'h0);
      add_row("rd_scr32_m0", M0, rd32, 16'h0200, 0, 32'h0, ok32, 2, 32'hdeadbeef);
      add_row("rd_scr16_m0", M0, rd16, 16'h0200, 0, 32'h0, ok16, 1, 32'hbeef);
      add_row("rd_scr32_m1", M1, rd32, 16'h0200, 0, 32'h0, ok32, 2, 32'h0);
      add_row("rd_scr32_m1_w16", M1, rd32, 16'h0201, 0, 32'h0, ok32, 2, 32'h00005a5a);
      // Error responses end on the flags flit
      add_row("err_wr_vendor_m0", M0, wr16, osd_pkg::REG_VENDOR, 1, 32'h1234, w_err, 0, 32'h0);
      add_row("err_wr32_cs_m1", M1, wr32, osd_pkg::REG_CS, 2, 32'h00000001, w_err, 0, 32'h0);
      add_row("err_wr_nodata_m0", M0, wr16, osd_pkg::REG_CS, 0, 32'h0, w_err, 0, 32'h0);
      expect_ports(2'b10, 16'h0005, 16'h0123);
      add_row("err_rd_oob_m1", M1, rd16, 16'h0210, 0, 32'h0, r_err, 0, 32'h0);
      add_row("err_wr_oob_m0", M0, wr16, 16'h0204, 1, 32'h0001, w_err, 0, 32'h0);
      add_row("err_rd64_m0", M0, rd64, 16'h0200, 0, 32'h0, r_err, 0, 32'h0);
      // Silent drops, then a normal row
      add_drop("drop_type_m0", M0, bad_type, osd_pkg::REG_VENDOR);
      add_drop("drop_dest", 16'h0033, rd16, osd_pkg::REG_VENDOR);
      add_row("rd_version_m1", M1, rd16, osd_pkg::REG_VERSION, 0, 32'h0, ok16, 1, 32'h0003);
      // Back to back, alternating modules
      add_row("alt_wr_scr_m1", M1, wr32, 16'h0203, 2, 32'h12345678, w_ok, 0, 32'h0);
      add_row("alt_rd_scr_m0", M0, rd32, 16'h0200, 0, 32'h0, ok32, 2, 32'hdeadbeef);
      add_row("alt_rd_scr_m1", M1, rd32, 16'h0203, 0, 32'h0, ok32, 2, 32'h12345678);
      add_row("alt_rd_vendor_m0", M0, rd16, osd_pkg::REG_VENDOR, 0, 32'h0, ok16, 1, 32'h0001);
      add_row("alt_rd_type_m1", M1, rd16, osd_pkg::REG_TYPE, 0, 32'h0, ok16, 1, 32'h0002);
      add_row("alt_rd_cs_m0", M0, rd16, osd_pkg::REG_CS, 0, 32'h0, ok16, 1, 32'h0001);
   endtask

   task automatic send_row(input int r);
      int   m;
      logic last_flit;
      m = (t_rsp[r][1] == M1) ? 1 : 0;
      for (int i = 0; i < t_rsp_n[r]; i++) begin
         last_flit = (i == t_rsp_n[r] - 1);
         exp_q[m].push_back({last_flit, t_rsp[r][i]});
         exp_name[m].push_back(t_name[r]);
      end
      if (t_rsp_n[r] > 0)
         sent_pkts++;
      for (int i = 0; i < t_req_n[r]; i++) begin
         @(negedge clk);
         in_valid = 1'b1;
         in_data = t_req[r][i];
         in_last = (i == t_req_n[r] - 1);
         @(posedge clk);
         while (!in_ready)
            @(posedge clk);
      end
      @(negedge clk);
      in_valid = 1'b0;
      in_last = 1'b0;
   endtask

   task automatic wait_idle();
      while (got_pkts != sent_pkts)
         @(negedge clk);
   endtask

   task automatic check_ports(input int r);
      wait_idle();
      @(negedge clk);
      assert ({stall_1, stall_0} == t_stall[r])
         else fail_run($sformatf("[ERROR] %s stall expected %b actual %b",
                                 t_name[r], t_stall[r], {stall_1, stall_0}));
      assert (event_dest_0 == t_ev0[r])
         else fail_run($sformatf("[ERROR] %s event_dest_0 expected %h actual %h",
                                 t_name[r], t_ev0[r], event_dest_0));
      assert (event_dest_1 == t_ev1[r])
         else fail_run($sformatf("[ERROR] %s event_dest_1 expected %h actual %h",
                                 t_name[r], t_ev1[r], event_dest_1));
   endtask

   // Whole packet is matched against the queue of its source module
   task automatic check_packet();
      int          m;
      logic [16:0] want;
      string       name;
      assert (pkt.size() >= 3)
         else fail_run($sformatf("Response of %0d flits is too short", pkt.size()));
      assert (pkt[1][15:0] == M0 || pkt[1][15:0] == M1)
         else fail_run($sformatf("Response from unknown source %h", pkt[1][15:0]));
      m = (pkt[1][15:0] == M1) ? 1 : 0;
      foreach (pkt[i]) begin
         assert (exp_q[m].size() > 0)
            else fail_run($sformatf("Unexpected response from module %0d", m));
         want = exp_q[m].pop_front();
         name = exp_name[m].pop_front();
         assert (pkt[i] == want)
            else fail_run($sformatf("[ERROR] %s expected %b/%h actual %b/%h", name,
                                    want[16], want[15:0], pkt[i][16], pkt[i][15:0]));
      end
      pkt.delete();
      got_pkts++;
   endtask

   always @(posedge clk) begin
      if (!rst && out_valid && out_ready) begin
         pkt.push_back({out_last, out_data});
         if (out_last)
            check_packet();
      end
   end

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // Output back-pressure
   initial begin
      void'($urandom(32'h4697));
      out_ready = 1'b0;
      forever begin
         @(negedge clk);
         out_ready = ($urandom_range(3) != 0);   // About 75% ready
      end
   end

   initial begin
      wait (table_done);
      repeat (CYCLES_PER_ROW * n_rows + 30) @(posedge clk);
      fail_run($sformatf("Run timed out after %0d cycles", CYCLES_PER_ROW * n_rows + 30));
   end

   initial begin
      rst = 1'b1;
      in_valid = 1'b0;
      in_data = '0;
      in_last = 1'b0;
      n_rows = 0;
      sent_pkts = 0;
      got_pkts = 0;
      build_table();
      table_done = 1'b1;
      repeat (10) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      for (int r = 0; r < n_rows; r++) begin
         send_row(r);
         if (t_chk[r])
            check_ports(r);
      end
      wait_idle();
      repeat (20) @(posedge clk);   // Room for stray responses
      if (exp_q[0].size() == 0 && exp_q[1].size() == 0 && pkt.size() == 0) begin
         $display("TEST PASS");
         $finish;
      end else
         fail_run("Responses still outstanding at end of run");
   end

endmodule

/* osd_debug_subsys.sv */
`timescale 1ns/1ps

module osd_debug_subsys #(
   parameter logic [15:0] MOD_ID_0           = 16'h0010,
   parameter logic [15:0] MOD_ID_1           = 16'h0011,
   parameter logic [15:0] MOD_VENDOR         = 16'h0001,
   parameter logic [15:0] MOD_TYPE           = 16'h0002,
   parameter logic [15:0] MOD_VERSION        = 16'h0003,
   parameter logic [15:0] EVENT_DEST_DEFAULT = 16'h0000,
   parameter bit          CAN_STALL          = 1'b1,
   parameter int          MAX_REG_SIZE       = 32
) (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       in_valid,
   input  logic [osd_pkg::FLIT_W-1:0] in_data,
   input  logic                       in_last,
   output logic                       in_ready,
   output logic                       out_valid,
   output logic [osd_pkg::FLIT_W-1:0] out_data,
   output logic                       out_last,
   input  logic                       out_ready,
   output logic [15:0]                event_dest_0,
   output logic [15:0]                event_dest_1,
   output logic                       stall_0,
   output logic                       stall_1
);

   // Request side, demux to engines
   logic                       rq_valid [2];
   logic [osd_pkg::FLIT_W-1:0] rq_data [2];
   logic                       rq_last [2];
   logic                       rq_ready [2];
   // Response side, engines to arbiter
   logic                       rs_valid [2];
   logic [osd_pkg::FLIT_W-1:0] rs_data [2];
   logic                       rs_last [2];
   logic                       rs_ready [2];
   logic [15:0]                ev_dest [2];
   logic                       stall_w [2];

   osd_packet_demux #(
      .MOD_ID_0(MOD_ID_0),
      .MOD_ID_1(MOD_ID_1)
   ) u_demux (
      .clk(clk), .rst(rst),
      .in_valid(in_valid), .in_data(in_data), .in_last(in_last), .in_ready(in_ready),
      .m0_valid(rq_valid[0]), .m0_data(rq_data[0]), .m0_last(rq_last[0]),
      .m0_ready(rq_ready[0]),
      .m1_valid(rq_valid[1]), .m1_data(rq_data[1]), .m1_last(rq_last[1]),
      .m1_ready(rq_ready[1])
   );

   for (genvar g = 0; g < 2; g++) begin : g_mod
      localparam logic [15:0] ID = (g == 0) ? MOD_ID_0 : MOD_ID_1;

      logic                    reg_request, reg_write, reg_ack, reg_err;
      logic [15:0]             reg_addr;
      logic [1:0]              reg_size;
      logic [MAX_REG_SIZE-1:0] reg_wdata, reg_rdata;

      osd_regaccess #(
         .MOD_ID(ID), .MOD_VENDOR(MOD_VENDOR), .MOD_TYPE(MOD_TYPE),
         .MOD_VERSION(MOD_VERSION), .EVENT_DEST_DEFAULT(EVENT_DEST_DEFAULT),
         .CAN_STALL(CAN_STALL), .MAX_REG_SIZE(MAX_REG_SIZE)
      ) u_regaccess (
         .clk(clk), .rst(rst),
         .in_valid(rq_valid[g]), .in_data(rq_data[g]), .in_last(rq_last[g]),
         .in_ready(rq_ready[g]),
         .out_valid(rs_valid[g]), .out_data(rs_data[g]), .out_last(rs_last[g]),
         .out_ready(rs_ready[g]),
         .reg_request(reg_request), .reg_write(reg_write), .reg_addr(reg_addr),
         .reg_size(reg_size), .reg_wdata(reg_wdata),
         .reg_ack(reg_ack), .reg_err(reg_err), .reg_rdata(reg_rdata),
         .event_dest(ev_dest[g]), .stall(stall_w[g])
      );

      osd_scratch_regs #(.MAX_REG_SIZE(MAX_REG_SIZE)) u_scratch (
         .clk(clk), .rst(rst),
         .reg_request(reg_request), .reg_write(reg_write), .reg_addr(reg_addr),
         .reg_size(reg_size), .reg_wdata(reg_wdata),
         .reg_ack(reg_ack), .reg_err(reg_err), .reg_rdata(reg_rdata)
      );
   end

   osd_packet_arbiter u_arbiter (
      .clk(clk), .rst(rst),
      .s0_valid(rs_valid[0]), .s0_data(rs_data[0]), .s0_last(rs_last[0]),
      .s0_ready(rs_ready[0]),
      .s1_valid(rs_valid[1]), .s1_data(rs_data[1]), .s1_last(rs_last[1]),
      .s1_ready(rs_ready[1]),
      .out_valid(out_valid), .out_data(out_data), .out_last(out_last),
      .out_ready(out_ready)
   );

   assign event_dest_0 = ev_dest[0];
   assign event_dest_1 = ev_dest[1];
   assign stall_0 = stall_w[0];
   assign stall_1 = stall_w[1];

endmodule

/* osd_packet_arbiter.sv */
`timescale 1ns/1ps

module osd_packet_arbiter (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       s0_valid,
   input  logic [osd_pkg::FLIT_W-1:0] s0_data,
   input  logic                       s0_last,
   output logic                       s0_ready,
   input  logic                       s1_valid,
   input  logic [osd_pkg::FLIT_W-1:0] s1_data,
   input  logic                       s1_last,
   output logic                       s1_ready,
   output logic                       out_valid,
   output logic [osd_pkg::FLIT_W-1:0] out_data,
   output logic                       out_last,
   input  logic                       out_ready
);

   logic busy;         // Packet in flight
   logic grant;
   logic last_winner;
   logic pick, sel;

   // Last winner yields when both request
   assign pick = (s0_valid && s1_valid) ? ~last_winner : s1_valid;
   assign sel = busy ? grant : pick;

   assign out_valid = sel ? s1_valid : s0_valid;
   assign out_data = sel ? s1_data : s0_data;
   assign out_last = sel ? s1_last : s0_last;
   assign s0_ready = !sel && out_ready;
   assign s1_ready = sel && out_ready;

   always_ff @(posedge clk) begin
      if (rst) begin
         busy <= 1'b0;
         grant <= 1'b0;
         last_winner <= 1'b1;
      end else if (out_valid) begin
         busy <= !(out_ready && out_last);  // Locked once offered
         grant <= sel;
         last_winner <= sel;
      end
   end

   a_grant_locked: assert property (@(posedge clk) disable iff (rst)
      (out_valid && !(out_ready && out_last)) |=> sel == $past(sel));

endmodule

/* osd_packet_demux.sv */
`timescale 1ns/1ps

module osd_packet_demux #(
   parameter logic [15:0] MOD_ID_0 = 16'h0000,
   parameter logic [15:0] MOD_ID_1 = 16'h0001
) (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       in_valid,
   input  logic [osd_pkg::FLIT_W-1:0] in_data,
   input  logic                       in_last,
   output logic                       in_ready,
   output logic                       m0_valid,
   output logic [osd_pkg::FLIT_W-1:0] m0_data,
   output logic                       m0_last,
   input  logic                       m0_ready,
   output logic                       m1_valid,
   output logic [osd_pkg::FLIT_W-1:0] m1_data,
   output logic                       m1_last,
   input  logic                       m1_ready
);

   localparam logic [1:0] ROUTE_M0 = 2'd0,
                          ROUTE_M1 = 2'd1,
                          ROUTE_DROP = 2'd2;

   logic       in_pkt;
   logic [1:0] route, cur_route;

   // First flit is the destination
   always_comb begin
      if (in_pkt)
         cur_route = route;
      else if (in_data == MOD_ID_0)
         cur_route = ROUTE_M0;
      else if (in_data == MOD_ID_1)
         cur_route = ROUTE_M1;
      else
         cur_route = ROUTE_DROP;
   end

   assign m0_valid = in_valid && cur_route == ROUTE_M0;
   assign m1_valid = in_valid && cur_route == ROUTE_M1;
   assign m0_data = in_data;
   assign m1_data = in_data;
   assign m0_last = in_last;
   assign m1_last = in_last;
   assign in_ready = (cur_route == ROUTE_M0) ? m0_ready :
                     (cur_route == ROUTE_M1) ? m1_ready : 1'b1; // Swallow unknown

   always_ff @(posedge clk) begin
      if (rst) begin
         in_pkt <= 1'b0;
         route <= ROUTE_DROP;
      end else if (in_valid && in_ready) begin
         in_pkt <= !in_last;
         route <= cur_route;
      end
   end

endmodule

/* osd_regaccess.sv */
`timescale 1ns/1ps

module osd_regaccess #(
   parameter logic [15:0] MOD_ID             = 16'h0000,
   parameter logic [15:0] MOD_VENDOR         = 16'h0000,
   parameter logic [15:0] MOD_TYPE           = 16'h0000,
   parameter logic [15:0] MOD_VERSION        = 16'h0000,
   parameter logic [15:0] EVENT_DEST_DEFAULT = 16'h0000,
   parameter bit          CAN_STALL          = 1'b0,
   parameter int          MAX_REG_SIZE       = 32
) (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       in_valid,
   input  logic [osd_pkg::FLIT_W-1:0] in_data,
   input  logic                       in_last,
   output logic                       in_ready,
   output logic                       out_valid,
   output logic [osd_pkg::FLIT_W-1:0] out_data,
   output logic                       out_last,
   input  logic                       out_ready,
   output logic                       reg_request,
   output logic                       reg_write,
   output logic [15:0]                reg_addr,
   output logic [1:0]                 reg_size,
   output logic [MAX_REG_SIZE-1:0]    reg_wdata,
   input  logic                       reg_ack,
   input  logic                       reg_err,
   input  logic [MAX_REG_SIZE-1:0]    reg_rdata,
   output logic [15:0]                event_dest,
   output logic                       stall
);

   localparam logic [3:0] S_IDLE = 4'd0, // Request dest flit
                          S_SRC = 4'd1,
                          S_FLAGS = 4'd2,
                          S_ADDR = 4'd3,
                          S_WRITE = 4'd4,
                          S_DRAIN = 4'd5,  // Surplus flits, then respond
                          S_SKIP = 4'd6,   // Silent drop
                          S_EXT = 4'd7,
                          S_RESP_DEST = 4'd8,
                          S_RESP_SRC = 4'd9,
                          S_RESP_FLAGS = 4'd10,
                          S_RESP_DATA = 4'd11;

   logic [3:0]              state, state_nxt;
   logic                    cs_active, cs_active_nxt;
   logic [15:0]             event_dest_q, event_dest_nxt;
   logic                    req_write, req_write_nxt;
   logic [1:0]              req_size, req_size_nxt;
   logic [2:0]              word_it, word_it_nxt;
   logic [15:0]             req_addr, req_addr_nxt;
   logic [MAX_REG_SIZE-1:0] value, value_nxt;
   logic [15:0]             resp_dest, resp_dest_nxt;
   logic                    resp_error, resp_error_nxt;
   logic                    size_bad;
   logic                    in_ext, req_ext;
   osd_pkg::osd_flags_u     in_flags;
   osd_pkg::osd_flags_u     resp_flags;

   assign in_flags = in_data;
   assign in_ext = in_data >= osd_pkg::EXT_BASE;
   assign req_ext = req_addr >= osd_pkg::EXT_BASE;
   assign size_bad = (32'd16 << req_size) > MAX_REG_SIZE;

   assign reg_write = req_write;
   assign reg_addr = req_addr;
   assign reg_size = req_size;
   assign reg_wdata = value;
   assign event_dest = event_dest_q;
   assign stall = CAN_STALL & ~cs_active;

   always_comb begin
      state_nxt = state;
      cs_active_nxt = cs_active;
      event_dest_nxt = event_dest_q;
      req_write_nxt = req_write;
      req_size_nxt = req_size;
      word_it_nxt = word_it;
      req_addr_nxt = req_addr;
      value_nxt = value;
      resp_dest_nxt = resp_dest;
      resp_error_nxt = resp_error;
      in_ready = 1'b0;
      out_valid = 1'b0;
      out_data = '0;
      out_last = 1'b0;
      reg_request = 1'b0;
      resp_flags = '0;

      case (state)
         S_IDLE: begin
            in_ready = 1'b1;
            if (in_valid)
               state_nxt = in_last ? S_IDLE : S_SRC;
         end
         S_SRC: begin
            in_ready = 1'b1;
            if (in_valid) begin
               resp_dest_nxt = in_data;  // Response goes back to requester
               resp_error_nxt = 1'b0;
               state_nxt = in_last ? S_IDLE : S_FLAGS;
            end
         end
         S_FLAGS: begin
            in_ready = 1'b1;
            if (in_valid) begin
               req_write_nxt = in_flags.req.write;
               req_size_nxt = in_flags.req.size;
               word_it_nxt = 3'((4'd1 << in_flags.req.size) - 4'd1);
               if (in_last)
                  state_nxt = S_IDLE;
               else if (in_flags.req.ftype != osd_pkg::TYPE_REG)
                  state_nxt = S_SKIP;
               else
                  state_nxt = S_ADDR;
            end
         end
         S_ADDR: begin
            in_ready = 1'b1;
            if (in_valid) begin
               req_addr_nxt = in_data;
               value_nxt = '0;
               resp_error_nxt = 1'b0;
               if (size_bad)
                  resp_error_nxt = 1'b1;
               else if (in_ext)
                  resp_error_nxt = 1'b0;
               else if (req_write)
                  resp_error_nxt = !(req_size == osd_pkg::SIZE_16 &&
                                     (in_data == osd_pkg::REG_CS ||
                                      in_data == osd_pkg::REG_EVENT_DEST));
               else begin
                  case (in_data)
                     osd_pkg::REG_VENDOR:     value_nxt = MAX_REG_SIZE'(MOD_VENDOR);
                     osd_pkg::REG_TYPE:       value_nxt = MAX_REG_SIZE'(MOD_TYPE);
                     osd_pkg::REG_VERSION:    value_nxt = MAX_REG_SIZE'(MOD_VERSION);
                     osd_pkg::REG_CS:         value_nxt = MAX_REG_SIZE'(cs_active);
                     osd_pkg::REG_EVENT_DEST: value_nxt = MAX_REG_SIZE'(event_dest_q);
                     default:                 resp_error_nxt = 1'b1;
                  endcase
               end
               if (req_write && in_last)
                  resp_error_nxt = 1'b1;  // No data flit
               if (in_last)
                  state_nxt = (resp_error_nxt || !in_ext) ? S_RESP_DEST : S_EXT;
               else if (req_write && !resp_error_nxt)
                  state_nxt = S_WRITE;
               else
                  state_nxt = S_DRAIN;
            end
         end
         S_WRITE: begin
            in_ready = 1'b1;
            if (in_valid) begin
               value_nxt = (value << 16) | MAX_REG_SIZE'(in_data); // MS word first
               if (word_it == 3'd0) begin
                  if (!req_ext && req_addr == osd_pkg::REG_CS)
                     cs_active_nxt = in_data[0];
                  else if (!req_ext)
                     event_dest_nxt = in_data;
                  if (!in_last)
                     state_nxt = S_DRAIN;
                  else
                     state_nxt = req_ext ? S_EXT : S_RESP_DEST;
               end else if (in_last) begin
                  resp_error_nxt = 1'b1;  // Data ended early
                  state_nxt = S_RESP_DEST;
               end else
                  word_it_nxt = word_it - 3'd1;
            end
         end
         S_DRAIN: begin
            in_ready = 1'b1;
            if (in_valid && in_last)
               state_nxt = (req_ext && !resp_error) ? S_EXT : S_RESP_DEST;
         end
         S_SKIP: begin
            in_ready = 1'b1;
            if (in_valid && in_last)
               state_nxt = S_IDLE;
         end
         S_EXT: begin
            reg_request = 1'b1;
            if (reg_ack || reg_err) begin
               value_nxt = reg_rdata;
               resp_error_nxt = reg_err;
               state_nxt = S_RESP_DEST;
            end
         end
         S_RESP_DEST: begin
            out_valid = 1'b1;
            out_data = resp_dest;
            if (out_ready)
               state_nxt = S_RESP_SRC;
         end
         S_RESP_SRC: begin
            out_valid = 1'b1;
            out_data = MOD_ID;
            if (out_ready)
               state_nxt = S_RESP_FLAGS;
         end
         S_RESP_FLAGS: begin
            resp_flags.resp.ftype = osd_pkg::TYPE_REG;
            if (req_write)
               resp_flags.resp.subtype = resp_error ? osd_pkg::RESP_WRITE_ERR
                                                    : osd_pkg::RESP_WRITE_OK;
            else
               resp_flags.resp.subtype = resp_error ? osd_pkg::RESP_READ_ERR
                                                    : {osd_pkg::RESP_READ_OK, req_size};
            out_valid = 1'b1;
            out_data = resp_flags;
            out_last = req_write || resp_error;
            if (out_ready)
               state_nxt = out_last ? S_IDLE : S_RESP_DATA;
         end
         S_RESP_DATA: begin
            out_valid = 1'b1;
            out_data = 16'(value >> (16 * word_it));
            out_last = word_it == 3'd0;
            if (out_ready) begin
               if (word_it == 3'd0)
                  state_nxt = S_IDLE;
               else
                  word_it_nxt = word_it - 3'd1;
            end
         end
         default: state_nxt = S_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= S_IDLE;
         cs_active <= 1'b0;
         event_dest_q <= EVENT_DEST_DEFAULT;
      end else begin
         state <= state_nxt;
         cs_active <= cs_active_nxt;
         event_dest_q <= event_dest_nxt;
      end
      req_write <= req_write_nxt;
      req_size <= req_size_nxt;
      word_it <= word_it_nxt;
      req_addr <= req_addr_nxt;
      value <= value_nxt;
      resp_dest <= resp_dest_nxt;
      resp_error <= resp_error_nxt;
   end

   // No request flit is taken while the register bank owns the engine
   a_ext_blocks_input: assert property (@(posedge clk) disable iff (rst)
      reg_request |-> !in_ready);

endmodule

/* osd_scratch_regs.sv */
`timescale 1ns/1ps

module osd_scratch_regs #(
   parameter int MAX_REG_SIZE = 32
) (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    reg_request,
   input  logic                    reg_write,
   input  logic [15:0]             reg_addr,
   input  logic [1:0]              reg_size,
   input  logic [MAX_REG_SIZE-1:0] reg_wdata,
   output logic                    reg_ack,
   output logic                    reg_err,
   output logic [MAX_REG_SIZE-1:0] reg_rdata
);

   logic [MAX_REG_SIZE-1:0] regs [4];
   logic [MAX_REG_SIZE-1:0] size_mask;
   logic                    served;   // Request already answered
   logic                    bad;

   // Ones up to the access width
   assign size_mask = ~({MAX_REG_SIZE{1'b1}} << (16 << reg_size));
   assign bad = (reg_addr[15:2] != osd_pkg::EXT_BASE[15:2]) ||
                ((32'd16 << reg_size) > MAX_REG_SIZE);

   always_ff @(posedge clk) begin
      if (rst) begin
         reg_ack <= 1'b0;
         reg_err <= 1'b0;
         served <= 1'b0;
         for (int i = 0; i < 4; i++)
            regs[i] <= '0;
      end else begin
         reg_ack <= 1'b0;
         reg_err <= 1'b0;
         if (reg_request && !served) begin
            served <= 1'b1;
            if (bad)
               reg_err <= 1'b1;
            else begin
               reg_ack <= 1'b1;
               if (reg_write)
                  regs[reg_addr[1:0]] <= reg_wdata & size_mask;
            end
         end else if (!reg_request)
            served <= 1'b0;
      end
      reg_rdata <= regs[reg_addr[1:0]] & size_mask;
   end

   // Exactly one of ack and err, one cycle after the request rises
   a_one_response: assert property (@(posedge clk) disable iff (rst)
      $rose(reg_request) |=> (reg_ack ^ reg_err));

endmodule

/* osd_pkg.sv */
package osd_pkg;

   localparam int FLIT_W = 16;

   // Access size codes, words = 1 << code
   localparam logic [1:0] SIZE_16  = 2'b00;
   localparam logic [1:0] SIZE_32  = 2'b01;
   localparam logic [1:0] SIZE_64  = 2'b10;
   localparam logic [1:0] SIZE_128 = 2'b11;

   // Base register map
   localparam logic [15:0] REG_VENDOR     = 16'h0000;
   localparam logic [15:0] REG_TYPE       = 16'h0001;
   localparam logic [15:0] REG_VERSION    = 16'h0002;
   localparam logic [15:0] REG_CS         = 16'h0003; // Bit 0 is active
   localparam logic [15:0] REG_EVENT_DEST = 16'h0004;
   localparam logic [15:0] EXT_BASE       = 16'h0200;

   localparam logic [1:0] TYPE_REG = 2'b00;

   // Response subtypes
   localparam logic [3:0] RESP_WRITE_OK  = 4'b1110;
   localparam logic [3:0] RESP_WRITE_ERR = 4'b1111;
   localparam logic [3:0] RESP_READ_ERR  = 4'b1100;
   localparam logic [1:0] RESP_READ_OK   = 2'b10;   // Followed by size code

   // Flags flit, request and response views
   typedef union packed {
      struct packed {
         logic [1:0] ftype;
         logic       rsvd_hi;
         logic       write;
         logic [1:0] size;
         logic [9:0] rsvd_lo;
      } req;
      struct packed {
         logic [1:0] ftype;
         logic [3:0] subtype;
         logic [9:0] rsvd;
      } resp;
   } osd_flags_u;

endpackage
